// ==== dcr_pkg.sv ====
package dcr_pkg;

    localparam int DCR_ADDR_WIDTH = 12;
    localparam int DCR_DATA_WIDTH = 32;

    // word address of the counter-class register.
    localparam logic [DCR_ADDR_WIDTH-1:0] DCR_MPM_CLASS = 12'h002;

    // counter classes software can select for readout.
    localparam logic [DCR_DATA_WIDTH-1:0] MPM_CLASS_NONE = 32'd0;
    localparam logic [DCR_DATA_WIDTH-1:0] MPM_CLASS_CORE = 32'd1;

endpackage

// ==== perf_pkg.sv ====
package perf_pkg;

    localparam int CTR_BITS = 44;

    // widest lane vector the pop count accepts.
    localparam int MAX_LANES     = 32;
    localparam int LANE_CNT_BITS = $clog2(MAX_LANES + 1);

    typedef logic [CTR_BITS-1:0] ctr_t;

    typedef enum logic [2:0] {
        IFETCHES   = 3'd0,
        LOADS      = 3'd1,
        STORES     = 3'd2,
        IFETCH_LAT = 3'd3,
        LOAD_LAT   = 3'd4
    } perf_sel_t;

    function automatic logic [LANE_CNT_BITS-1:0] pop_count(input logic [MAX_LANES-1:0] lanes);
        logic [LANE_CNT_BITS-1:0] cnt;
        cnt = '0;
        for (int i = 0; i < MAX_LANES; i++) begin
            cnt = cnt + LANE_CNT_BITS'(lanes[i]);
        end
        return cnt;
    endfunction

endpackage

// ==== cache_bus_if.sv ====
`timescale 1ns/100ps

interface cache_bus_if #(
    parameter int NUM_REQS = 1
) ();

    // request channel, one bit per lane.
    logic [NUM_REQS-1:0] req_valid;
    logic [NUM_REQS-1:0] req_rw;
    logic [NUM_REQS-1:0] req_ready;

    // response channel, one bit per lane.
    logic [NUM_REQS-1:0] rsp_valid;
    logic [NUM_REQS-1:0] rsp_ready;

    // a passive observer sees both channels and drives nothing.
    modport monitor (
        input req_valid,
        input req_rw,
        input req_ready,
        input rsp_valid,
        input rsp_ready
    );

endinterface

// ==== cache_traffic_probe.sv ====
`timescale 1ns/100ps

module cache_traffic_probe #(
    parameter int NUM_REQS = 1
) (
    input  logic                clk,
    input  logic                reset,
    cache_bus_if.monitor        bus,
    output perf_pkg::ctr_t      reads,
    output perf_pkg::ctr_t      writes,
    output perf_pkg::ctr_t      latency
);

    localparam int LANE_W   = perf_pkg::MAX_LANES;
    localparam int CNT_W    = perf_pkg::LANE_CNT_BITS;
    localparam int CTR_BITS = perf_pkg::CTR_BITS;

    logic [NUM_REQS-1:0] rd_fire;
    logic [NUM_REQS-1:0] wr_fire;
    logic [NUM_REQS-1:0] rsp_fire;

    logic [CNT_W-1:0] rd_cnt;
    logic [CNT_W-1:0] wr_cnt;
    logic [CNT_W-1:0] rsp_cnt;

    logic signed [CNT_W:0]      pending_delta;
    logic signed [CTR_BITS-1:0] pending_reads;

    perf_pkg::ctr_t read_ctr;
    perf_pkg::ctr_t write_ctr;
    perf_pkg::ctr_t lat_ctr;

    assign rd_fire  = bus.req_valid & bus.req_ready & ~bus.req_rw;
    assign wr_fire  = bus.req_valid & bus.req_ready & bus.req_rw;
    assign rsp_fire = bus.rsp_valid & bus.rsp_ready;

    assign rd_cnt  = perf_pkg::pop_count(LANE_W'(rd_fire));
    assign wr_cnt  = perf_pkg::pop_count(LANE_W'(wr_fire));
    assign rsp_cnt = perf_pkg::pop_count(LANE_W'(rsp_fire));

    // net change of reads in flight this cycle. It may go negative.
    assign pending_delta = $signed({1'b0, rd_cnt}) - $signed({1'b0, rsp_cnt});

    always_ff @(posedge clk) begin
        if (reset) begin
            pending_reads <= '0;
        end else begin
            pending_reads <= pending_reads + CTR_BITS'(pending_delta);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            read_ctr  <= '0;
            write_ctr <= '0;
            lat_ctr   <= '0;
        end else begin
            read_ctr  <= read_ctr + perf_pkg::ctr_t'(rd_cnt);
            write_ctr <= write_ctr + perf_pkg::ctr_t'(wr_cnt);
            lat_ctr   <= lat_ctr + perf_pkg::ctr_t'(pending_reads); // every waiting read adds a cycle.
        end
    end

    assign reads   = read_ctr;
    assign writes  = write_ctr;
    assign latency = lat_ctr;

endmodule

// ==== perf_csr_unit.sv ====
`timescale 1ns/100ps

module perf_csr_unit (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                dcr_write_valid,
    input  logic [dcr_pkg::DCR_ADDR_WIDTH-1:0]  dcr_write_addr,
    input  logic [dcr_pkg::DCR_DATA_WIDTH-1:0]  dcr_write_data,
    input  perf_pkg::ctr_t                      ifetches,
    input  perf_pkg::ctr_t                      ifetch_latency,
    input  perf_pkg::ctr_t                      loads,
    input  perf_pkg::ctr_t                      stores,
    input  perf_pkg::ctr_t                      load_latency,
    input  logic                                rd_req,
    input  perf_pkg::perf_sel_t                 rd_sel,
    input  logic                                rd_hi,
    output logic                                ack,
    output logic [31:0]                         rd_data
);

    localparam int CTR_BITS = perf_pkg::CTR_BITS;

    typedef enum logic {
        RD_IDLE = 1'b0,
        RD_ACK  = 1'b1
    } rd_state_t;

    logic [dcr_pkg::DCR_DATA_WIDTH-1:0] mpm_class;

    rd_state_t      rd_state;
    perf_pkg::ctr_t sel_ctr;
    logic [31:0]    sel_half;
    logic [31:0]    rd_value;

    always_ff @(posedge clk) begin
        if (reset) begin
            mpm_class <= dcr_pkg::MPM_CLASS_NONE;
        end else if (dcr_write_valid && dcr_write_addr == dcr_pkg::DCR_MPM_CLASS) begin
            mpm_class <= dcr_write_data;
        end
    end

    always_comb begin
        case (rd_sel)
            perf_pkg::IFETCHES:   sel_ctr = ifetches;
            perf_pkg::LOADS:      sel_ctr = loads;
            perf_pkg::STORES:     sel_ctr = stores;
            perf_pkg::IFETCH_LAT: sel_ctr = ifetch_latency;
            perf_pkg::LOAD_LAT:   sel_ctr = load_latency;
            default:              sel_ctr = '0;
        endcase
    end

    // the upper half is zero-extended to a full word.
    assign sel_half = rd_hi ? 32'(sel_ctr[CTR_BITS-1:32]) : sel_ctr[31:0];
    assign rd_value = (mpm_class == dcr_pkg::MPM_CLASS_CORE) ? sel_half : 32'd0;

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_state <= RD_IDLE;
            rd_data  <= '0;
        end else begin
            case (rd_state)
                RD_IDLE: begin
                    if (rd_req) begin
                        rd_state <= RD_ACK;
                        rd_data  <= rd_value; // captured once, held for the whole handshake.
                    end
                end
                RD_ACK: begin
                    if (!rd_req) begin
                        rd_state <= RD_IDLE;
                    end
                end
                default: rd_state <= RD_IDLE;
            endcase
        end
    end

    assign ack = (rd_state == RD_ACK);

endmodule

// ==== core_perf_top.sv ====
`timescale 1ns/100ps

module core_perf_top #(
    parameter int ICACHE_NUM_REQS = 1,
    parameter int DCACHE_NUM_REQS = 4
) (
    input  logic                                clk,
    input  logic                                reset,

    input  logic                                dcr_write_valid,
    input  logic [dcr_pkg::DCR_ADDR_WIDTH-1:0]  dcr_write_addr,
    input  logic [dcr_pkg::DCR_DATA_WIDTH-1:0]  dcr_write_data,

    input  logic [ICACHE_NUM_REQS-1:0]          icache_req_valid,
    input  logic [ICACHE_NUM_REQS-1:0]          icache_req_ready,
    input  logic [ICACHE_NUM_REQS-1:0]          icache_rsp_valid,
    input  logic [ICACHE_NUM_REQS-1:0]          icache_rsp_ready,

    input  logic [DCACHE_NUM_REQS-1:0]          dcache_req_valid,
    input  logic [DCACHE_NUM_REQS-1:0]          dcache_req_rw,
    input  logic [DCACHE_NUM_REQS-1:0]          dcache_req_ready,
    input  logic [DCACHE_NUM_REQS-1:0]          dcache_rsp_valid,
    input  logic [DCACHE_NUM_REQS-1:0]          dcache_rsp_ready,

    input  logic                                rd_req,
    input  perf_pkg::perf_sel_t                 rd_sel,
    input  logic                                rd_hi,
    output logic                                ack,
    output logic [31:0]                         rd_data
);

    perf_pkg::ctr_t ifetches;
    perf_pkg::ctr_t ifetch_latency;
    perf_pkg::ctr_t loads;
    perf_pkg::ctr_t stores;
    perf_pkg::ctr_t load_latency;

    cache_bus_if #(.NUM_REQS(ICACHE_NUM_REQS)) icache_bus ();
    cache_bus_if #(.NUM_REQS(DCACHE_NUM_REQS)) dcache_bus ();

    assign icache_bus.req_valid = icache_req_valid;
    assign icache_bus.req_rw    = '0; // instruction fetches never write.
    assign icache_bus.req_ready = icache_req_ready;
    assign icache_bus.rsp_valid = icache_rsp_valid;
    assign icache_bus.rsp_ready = icache_rsp_ready;

    assign dcache_bus.req_valid = dcache_req_valid;
    assign dcache_bus.req_rw    = dcache_req_rw;
    assign dcache_bus.req_ready = dcache_req_ready;
    assign dcache_bus.rsp_valid = dcache_rsp_valid;
    assign dcache_bus.rsp_ready = dcache_rsp_ready;

    cache_traffic_probe #(
        .NUM_REQS (ICACHE_NUM_REQS)
    ) u_icache_probe (
        .clk     (clk),
        .reset   (reset),
        .bus     (icache_bus.monitor),
        .reads   (ifetches),
        .writes  (),
        .latency (ifetch_latency)
    );

    cache_traffic_probe #(
        .NUM_REQS (DCACHE_NUM_REQS)
    ) u_dcache_probe (
        .clk     (clk),
        .reset   (reset),
        .bus     (dcache_bus.monitor),
        .reads   (loads),
        .writes  (stores),
        .latency (load_latency)
    );

    perf_csr_unit u_csr (
        .clk             (clk),
        .reset           (reset),
        .dcr_write_valid (dcr_write_valid),
        .dcr_write_addr  (dcr_write_addr),
        .dcr_write_data  (dcr_write_data),
        .ifetches        (ifetches),
        .ifetch_latency  (ifetch_latency),
        .loads           (loads),
        .stores          (stores),
        .load_latency    (load_latency),
        .rd_req          (rd_req),
        .rd_sel          (rd_sel),
        .rd_hi           (rd_hi),
        .ack             (ack),
        .rd_data         (rd_data)
    );

endmodule

// ==== tb_perf_checker.sv ====
`timescale 1ns/100ps

module tb_perf_checker #(
    parameter int IC_LANES = 1,
    parameter int DC_LANES = 4
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               dcr_write_valid,
    input  logic [dcr_pkg::DCR_ADDR_WIDTH-1:0] dcr_write_addr,
    input  logic [dcr_pkg::DCR_DATA_WIDTH-1:0] dcr_write_data,
    input  logic [IC_LANES-1:0]                icache_req_valid,
    input  logic [IC_LANES-1:0]                icache_req_ready,
    input  logic [IC_LANES-1:0]                icache_rsp_valid,
    input  logic [IC_LANES-1:0]                icache_rsp_ready,
    input  logic [DC_LANES-1:0]                dcache_req_valid,
    input  logic [DC_LANES-1:0]                dcache_req_rw,
    input  logic [DC_LANES-1:0]                dcache_req_ready,
    input  logic [DC_LANES-1:0]                dcache_rsp_valid,
    input  logic [DC_LANES-1:0]                dcache_rsp_ready,
    input  logic                               rd_req,
    input  perf_pkg::perf_sel_t                rd_sel,
    input  logic                               rd_hi,
    input  logic                               ack,
    input  logic [31:0]                        rd_data,
    input  logic                               test_end,
    input  int                                 test_id,
    input  logic                               finish_req,
    input  int                                 driver_errors,
    output logic                               report_done,
    output int                                 error_count
);

    localparam logic [63:0] CTR_MASK = (64'd1 << perf_pkg::CTR_BITS) - 64'd1;

    logic [63:0] shadow [5]; // ifetches, loads, stores, ifetch latency, load latency.
    logic [31:0] mpm_class;
    logic [31:0] expect_data;
    logic        rise_due;
    logic        fall_due;
    int          ic_pend;
    int          dc_pend;
    int          checks       = 0;
    int          errors       = 0;
    int          checks_base  = 0;
    int          errors_base  = 0;
    int          tests_run    = 0;
    int          tests_failed = 0;

    assign error_count = errors + driver_errors;

    function automatic int count_ones(input logic [31:0] v);
        int n;
        n = 0;
        for (int i = 0; i < 32; i++) begin
            n += int'(v[i]);
        end
        return n;
    endfunction

    // software sees zero unless the core class is selected.
    function automatic logic [31:0] expected_read(input int sel, input logic hi,
                                                  input logic [31:0] cls);
        logic [63:0] value;
        value = 64'd0;
        if (sel < 5) begin
            value = shadow[sel] & CTR_MASK;
        end
        if (cls != dcr_pkg::MPM_CLASS_CORE) begin
            return 32'd0;
        end
        return hi ? value[63:32] : value[31:0];
    endfunction

    function automatic string test_name(input int id);
        case (id)
            1: return "reset values";
            2: return "class gating";
            3: return "fire counts";
            4: return "latency";
            5: return "hi halves";
            6: return "handshake and reset";
            default: return "unknown";
        endcase
    endfunction

    always @(posedge clk) begin
        int ic_rd;
        int ic_rsp;
        int dc_rd;
        int dc_wr;
        int dc_rsp;
        int cur_errors;
        ic_rd  = count_ones(32'(icache_req_valid & icache_req_ready));
        ic_rsp = count_ones(32'(icache_rsp_valid & icache_rsp_ready));
        dc_rd  = count_ones(32'(dcache_req_valid & dcache_req_ready & ~dcache_req_rw));
        dc_wr  = count_ones(32'(dcache_req_valid & dcache_req_ready & dcache_req_rw));
        dc_rsp = count_ones(32'(dcache_rsp_valid & dcache_rsp_ready));
        if (reset) begin
            for (int i = 0; i < 5; i++) begin
                shadow[i] = 64'd0;
            end
            ic_pend     = 0;
            dc_pend     = 0;
            mpm_class   = dcr_pkg::MPM_CLASS_NONE;
            expect_data = 32'd0;
            rise_due    = 1'b0;
            fall_due    = 1'b0;
            report_done <= 1'b0;
        end else begin
            if (rise_due && !ack) begin
                $display("ack did not rise in the cycle after rd_req was seen");
                errors++;
            end
            if (fall_due && ack) begin
                $display("ack stayed high in the cycle after rd_req dropped");
                errors++;
            end
            if (ack) begin
                checks++;
                if (rd_data !== expect_data) begin
                    $display("Mismatch rd_data: sel %0d hi %0d expected 0x%08h got 0x%08h",
                             int'(rd_sel), rd_hi, expect_data, rd_data);
                    errors++;
                end
            end
            rise_due = rd_req && !ack;
            fall_due = ack && !rd_req;
            if (rd_req && !ack) begin
                expect_data = expected_read(int'(rd_sel), rd_hi, mpm_class);
            end
            shadow[0] += 64'(ic_rd);
            shadow[1] += 64'(dc_rd);
            shadow[2] += 64'(dc_wr);
            shadow[3] += 64'(ic_pend); // reads in flight before this edge.
            shadow[4] += 64'(dc_pend);
            ic_pend += ic_rd - ic_rsp;
            dc_pend += dc_rd - dc_rsp;
            if (dcr_write_valid && dcr_write_addr == dcr_pkg::DCR_MPM_CLASS) begin
                mpm_class = dcr_write_data;
            end
        end
        if (test_end) begin
            cur_errors = errors + driver_errors;
            $display("test %0d %s: %s, %0d checks, %0d errors", test_id, test_name(test_id),
                     (cur_errors == errors_base) ? "ok" : "failed", checks - checks_base,
                     cur_errors - errors_base);
            tests_run++;
            if (cur_errors != errors_base) begin
                tests_failed++;
            end
            errors_base = cur_errors;
            checks_base = checks;
        end
        if (finish_req && !report_done) begin
            $display("%0d tests, %0d failed, %0d checks, %0d errors", tests_run, tests_failed,
                     checks, errors + driver_errors);
            report_done <= 1'b1;
        end
    end

endmodule

// ==== tb_core_perf.sv ====
`timescale 1ns/100ps

module tb_core_perf;

    localparam int IC_LANES     = 1;
    localparam int DC_LANES     = 4;
    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 16;
    localparam int WAIT_LIMIT   = 16;
    localparam int RUN_CYCLES   = RESET_CYCLES + 150 + 400 + 650 + 650 + 3300 + 600;
    localparam int WATCHDOG_NS  = RUN_CYCLES * CLK_PERIOD * 2;

    logic                               clk;
    logic                               reset;
    logic                               dcr_write_valid;
    logic [dcr_pkg::DCR_ADDR_WIDTH-1:0] dcr_write_addr;
    logic [dcr_pkg::DCR_DATA_WIDTH-1:0] dcr_write_data;
    logic [IC_LANES-1:0]                icache_req_valid;
    logic [IC_LANES-1:0]                icache_req_ready;
    logic [IC_LANES-1:0]                icache_rsp_valid;
    logic [IC_LANES-1:0]                icache_rsp_ready;
    logic [DC_LANES-1:0]                dcache_req_valid;
    logic [DC_LANES-1:0]                dcache_req_rw;
    logic [DC_LANES-1:0]                dcache_req_ready;
    logic [DC_LANES-1:0]                dcache_rsp_valid;
    logic [DC_LANES-1:0]                dcache_rsp_ready;
    logic                               rd_req;
    perf_pkg::perf_sel_t                rd_sel;
    logic                               rd_hi;
    logic                               ack;
    logic [31:0]                        rd_data;
    logic                               test_end;
    int                                 test_id;
    logic                               finish_req;
    logic                               report_done;
    int                                 driver_errors;
    int                                 error_count;
    logic [31:0]                        lfsr_state;
    int                                 ic_pend;
    int                                 dc_pend;

    core_perf_top #(
        .ICACHE_NUM_REQS (IC_LANES),
        .DCACHE_NUM_REQS (DC_LANES)
    ) u_dut (.*);

    tb_perf_checker #(
        .IC_LANES (IC_LANES),
        .DC_LANES (DC_LANES)
    ) u_chk (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("SIMULATION FAILED");
        $finish;
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            bits = {bits[30:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    function automatic logic [31:0] lane_bits(input int n, input bit dense);
        logic [31:0] bits;
        bits = rand_bits(n);
        if (dense) begin
            bits = bits | rand_bits(n); // three lanes in four are set on average.
        end
        return bits;
    endfunction

    // keeps at most budget set bits, lowest lanes first.
    function automatic logic [31:0] keep_lowest(input logic [31:0] mask, input int budget);
        logic [31:0] kept;
        int          left;
        kept = '0;
        left = budget;
        for (int i = 0; i < 32; i++) begin
            if (mask[i] && left > 0) begin
                kept[i] = 1'b1;
                left--;
            end
        end
        return kept;
    endfunction

    function automatic int ones(input logic [31:0] v);
        int n;
        n = 0;
        for (int i = 0; i < 32; i++) begin
            n += int'(v[i]);
        end
        return n;
    endfunction

    task automatic bus_idle();
        icache_req_valid = '0;
        icache_req_ready = '0;
        icache_rsp_valid = '0;
        icache_rsp_ready = '0;
        dcache_req_valid = '0;
        dcache_req_rw    = '0;
        dcache_req_ready = '0;
        dcache_rsp_valid = '0;
        dcache_rsp_ready = '0;
    endtask

    // mode 0 is light traffic, 1 dense, 2 keeps every dcache lane requesting.
    task automatic traffic(input int cycles, input int mode);
        logic [31:0] v;
        logic [31:0] r;
        logic [31:0] rw;
        logic [31:0] rv;
        logic [31:0] rr;
        for (int c = 0; c < cycles; c++) begin
            @(negedge clk);
            v  = lane_bits(IC_LANES, mode > 0);
            r  = lane_bits(IC_LANES, mode > 0);
            rv = keep_lowest(lane_bits(IC_LANES, mode > 0), ic_pend);
            rr = lane_bits(IC_LANES, 1'b1);
            icache_req_valid = v[IC_LANES-1:0];
            icache_req_ready = r[IC_LANES-1:0];
            icache_rsp_valid = rv[IC_LANES-1:0];
            icache_rsp_ready = rr[IC_LANES-1:0];
            ic_pend += ones(v & r) - ones(rv & rr);
            v  = (mode == 2) ? (32'd1 << DC_LANES) - 32'd1 : lane_bits(DC_LANES, mode > 0);
            r  = lane_bits(DC_LANES, mode > 0);
            rw = rand_bits(DC_LANES);
            rv = (mode == 2) ? (32'd1 << DC_LANES) - 32'd1 : lane_bits(DC_LANES, mode > 0);
            rv = keep_lowest(rv, dc_pend); // only reads already in flight get a response.
            rr = lane_bits(DC_LANES, 1'b1);
            dcache_req_valid = v[DC_LANES-1:0];
            dcache_req_ready = r[DC_LANES-1:0];
            dcache_req_rw    = rw[DC_LANES-1:0];
            dcache_rsp_valid = rv[DC_LANES-1:0];
            dcache_rsp_ready = rr[DC_LANES-1:0];
            dc_pend += ones(v & r & ~rw) - ones(rv & rr);
        end
    endtask

    task automatic drain_reads();
        logic [31:0] rv;
        while (ic_pend > 0 || dc_pend > 0) begin
            @(negedge clk);
            bus_idle();
            rv = keep_lowest(32'hffff_ffff, ic_pend);
            icache_rsp_valid = rv[IC_LANES-1:0];
            icache_rsp_ready = '1;
            ic_pend -= ones(32'(icache_rsp_valid));
            rv = keep_lowest(32'hffff_ffff, dc_pend);
            dcache_rsp_valid = rv[DC_LANES-1:0];
            dcache_rsp_ready = '1;
            dc_pend -= ones(32'(dcache_rsp_valid));
        end
        @(negedge clk);
        bus_idle();
        repeat (4) @(negedge clk);
    endtask

    task automatic apply_reset();
        @(negedge clk);
        reset = 1'b1;
        rd_req = 1'b0;
        bus_idle();
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        ic_pend = 0;
        dc_pend = 0;
    endtask

    task automatic dcr_write(input logic [11:0] addr, input logic [31:0] data);
        @(negedge clk);
        dcr_write_valid = 1'b1;
        dcr_write_addr  = addr;
        dcr_write_data  = data;
        @(negedge clk);
        dcr_write_valid = 1'b0;
    endtask

    task automatic read_counter(input int sel, input bit hi, input int extra);
        int n;
        @(negedge clk);
        rd_sel = perf_pkg::perf_sel_t'(sel[2:0]);
        rd_hi  = hi;
        rd_req = 1'b1;
        n = 0;
        while (!ack && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!ack) begin
            $display("read of counter %0d half %0d got no ack", sel, hi);
            driver_errors++;
        end
        repeat (extra) @(negedge clk);
        rd_req = 1'b0;
        n = 0;
        while (ack && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (ack) begin
            $display("ack of counter %0d stayed high after rd_req dropped", sel);
            driver_errors++;
        end
    endtask

    task automatic read_all(input bit both_halves, input int max_extra);
        int extra [10];
        int reads;
        int k;
        reads = both_halves ? 10 : 5;
        for (int i = 0; i < reads; i++) begin
            extra[i] = (max_extra > 0) ? int'(rand_bits(3)) % (max_extra + 1) : 0;
        end
        k = 0;
        for (int sel = 0; sel < 5; sel++) begin
            for (int hi = 0; hi < (both_halves ? 2 : 1); hi++) begin
                read_counter(sel, hi[0], extra[k]);
                k++;
            end
        end
    endtask

    task automatic end_test(input int id);
        @(negedge clk);
        test_id  = id;
        test_end = 1'b1;
        @(negedge clk);
        test_end = 1'b0;
    endtask

    initial begin
        lfsr_state      = 32'hc572;
        ic_pend         = 0;
        dc_pend         = 0;
        driver_errors   = 0;
        reset           = 1'b1;
        dcr_write_valid = 1'b0;
        dcr_write_addr  = '0;
        dcr_write_data  = '0;
        rd_req          = 1'b0;
        rd_sel          = perf_pkg::IFETCHES;
        rd_hi           = 1'b0;
        test_end        = 1'b0;
        test_id         = 0;
        finish_req      = 1'b0;
        bus_idle();
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;

        dcr_write(dcr_pkg::DCR_MPM_CLASS, dcr_pkg::MPM_CLASS_CORE);
        read_all(1'b1, 0);
        end_test(1);
        apply_reset(); // the class returns to none for the next test.

        traffic(200, 0);
        drain_reads();
        read_all(1'b0, 0);
        dcr_write(12'h003, dcr_pkg::MPM_CLASS_CORE);
        read_counter(0, 1'b0, 0);
        dcr_write(dcr_pkg::DCR_MPM_CLASS, dcr_pkg::MPM_CLASS_CORE);
        read_all(1'b0, 0);
        end_test(2);

        traffic(500, 0);
        drain_reads();
        read_all(1'b0, 0);
        end_test(3);

        traffic(500, 1);
        drain_reads();
        read_all(1'b0, 0);
        end_test(4);

        traffic(3000, 2);
        drain_reads();
        read_all(1'b1, 0);
        end_test(5);

        fork
            traffic(150, 1);
            read_all(1'b1, 7); // counters keep moving while each read is held.
        join
        apply_reset();
        traffic(100, 1);
        drain_reads();
        read_all(1'b0, 0);
        dcr_write(dcr_pkg::DCR_MPM_CLASS, dcr_pkg::MPM_CLASS_CORE);
        read_all(1'b1, 3);
        end_test(6);

        @(negedge clk);
        finish_req = 1'b1;
        wait (report_done);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== build.f ====
dcr_pkg.sv
perf_pkg.sv
cache_bus_if.sv
cache_traffic_probe.sv
perf_csr_unit.sv
core_perf_top.sv
tb_perf_checker.sv
tb_core_perf.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f build.f --top-module tb_core_perf -o tb_core_perf
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_core_perf > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^SIMULATION PASSED$" "$LOG"; then
    exit 0
fi
exit 1
